//--- Bender.yml
package:
  name: btb_top

sources:
  # Packages first, then the blocks, top level last
  - logic/btb_geom_pkg.sv
  - logic/btb_types_pkg.sv
  - logic/btb_refill_buf.sv
  - logic/btb_inv_ctrl.sv
  - logic/btb_array.sv
  - logic/btb_top.sv

  # Simulation only
  - target: test
    files:
      - verification/tb_btb_top.sv

//--- logic/btb_array.sv
// Contents undefined after reset until one invalidation walk completes; one access per cycle, reads lose to writes
`timescale 1ns/1ps

module btb_array
  import btb_geom_pkg::*, btb_types_pkg::*;
(
  input  logic            refill_buf_updt_clk,
  input  logic            cpurst_b,
  input  logic            cp0_ifu_btb_en,
  input  btb_lookup_req_t lookup,
  input  btb_refill_wr_t  refill_wr,
  input  btb_inv_t        inv,
  output btb_set_t        result,
  output logic            result_vld
);

  // Storage, one four-way set per entry
  btb_set_t mem [BTB_SETS];

  // Shared index and per-cycle operation
  logic [BTB_INDEX_W-1:0]       arr_index;
  logic                         inv_wr;
  logic                         refill_en;
  logic                         rd_en;
  logic [$clog2(BTB_WAYS)-1:0]  way_sel;
  // Registered read set before enable gating
  btb_set_t                     rd_set;

  //======================================================================
  //  Port priority
  //======================================================================
  // Invalidation first, then refill, then lookup
  assign inv_wr    = inv.active;
  assign refill_en = !inv.active && cp0_ifu_btb_en && refill_wr.vld;
  // Lookup dropped whenever a write owns the array
  assign rd_en     = !inv.active && !refill_wr.vld && cp0_ifu_btb_en && lookup.vld;

  always_comb
  begin
    if (inv.active)
      arr_index = inv.index;
    else if (refill_wr.vld)
      arr_index = refill_wr.index;
    else
      arr_index = lookup.index;
  end

  // Tag bits 2 and 1 spread entries over the ways
  assign way_sel = refill_wr.entry.tag[BTB_WAYSEL_LSB +: $clog2(BTB_WAYS)];

  //======================================================================
  //  Storage write
  //======================================================================
  // Walk clears the whole set
  // Refill touches only the selected way
  always_ff @(posedge refill_buf_updt_clk)
  begin
    if (inv_wr)
      mem[arr_index] <= '0;
    else if (refill_en)
      mem[arr_index].way[way_sel] <= refill_wr.entry;
  end

  //======================================================================
  //  Read register
  //======================================================================
  // Set held until the next accepted lookup
  always_ff @(posedge refill_buf_updt_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rd_set     <= '0;
      result_vld <= 1'b0;
    end
    else
    begin
      // One-cycle pulse per accepted lookup
      result_vld <= rd_en;
      if (rd_en)
        rd_set <= mem[arr_index];
    end
  end

  //======================================================================
  //  Output gating
  //======================================================================
  // BTB off hides every way, payload passes unchanged
  always_comb
  begin
    result = rd_set;
    for (int w = 0; w < BTB_WAYS; w++)
    begin
      result.way[w].vld = rd_set.way[w].vld && cp0_ifu_btb_en;
    end
  end

endmodule

//--- logic/btb_geom_pkg.sv
// Four-way BTB geometry; BTB_SETS must stay equal to 2**BTB_INDEX_W so one walk covers every set
package btb_geom_pkg;

  //======================================================================
  //  Array shape
  //======================================================================
  // Ways per set
  localparam int unsigned BTB_WAYS = 4;
  // Set index bits, taken from the fetch PC
  localparam int unsigned BTB_INDEX_W = 9;
  // Sets in the array
  localparam int unsigned BTB_SETS = 1 << BTB_INDEX_W;

  //======================================================================
  //  Entry fields
  //======================================================================
  // Partial tag kept per way
  localparam int unsigned BTB_TAG_W = 10;
  // Only the low target PC bits are stored
  localparam int unsigned BTB_TARGET_W = 20;
  // Icache way prediction carried with the target
  localparam int unsigned BTB_WAYPRED_W = 2;

  // Lowest tag bit of the write-way select, tag[2:1] picks the way
  localparam int unsigned BTB_WAYSEL_LSB = 1;

  // Buffered way prediction after reset or invalidation
  localparam logic [BTB_WAYPRED_W-1:0] BTB_WAYPRED_RST = '1;

endpackage

//--- logic/btb_inv_ctrl.sv
// Walk always covers all BTB_SETS sets, highest first; requests during a walk are dropped, not queued
`timescale 1ns/1ps

module btb_inv_ctrl
  import btb_geom_pkg::*, btb_types_pkg::*;
(
  input  logic     refill_buf_updt_clk,
  input  logic     cpurst_b,
  input  logic     ifctrl_btb_inv,
  output btb_inv_t inv,
  output logic     inv_on,
  output logic     inv_done
);

  // Walk state
  logic                   inv_active;
  logic [BTB_INDEX_W-1:0] inv_cnt;

  //======================================================================
  //  Walk counter
  //======================================================================
  // Loaded with the top set, counts down once per cycle
  // Flag drops on the edge that sees set 0
  always_ff @(posedge refill_buf_updt_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      inv_active <= 1'b0;
      inv_cnt    <= '0;
    end
    else if (inv_active)
    begin
      inv_cnt <= inv_cnt - 1'b1;
      if (inv_cnt == '0)
        inv_active <= 1'b0;
    end
    else if (ifctrl_btb_inv)
    begin
      inv_active <= 1'b1;
      inv_cnt    <= BTB_INDEX_W'(BTB_SETS - 1);
    end
  end

  //======================================================================
  //  Status
  //======================================================================
  // Array clears inv.index on every active cycle
  assign inv.active = inv_active;
  assign inv.index  = inv_cnt;

  assign inv_on   = inv_active;
  assign inv_done = !inv_active;

endmodule

//--- logic/btb_refill_buf.sv
// Holds one pending entry; a second update before the miss overwrites it and a miss with no valid entry writes nothing
`timescale 1ns/1ps

module btb_refill_buf
  import btb_geom_pkg::*, btb_types_pkg::*;
(
  input  logic                     refill_buf_updt_clk,
  input  logic                     cpurst_b,
  input  btb_update_t              update,
  input  logic [BTB_WAYPRED_W-1:0] way_pred,
  input  logic                     pcgen_stall,
  input  logic                     ibdp_btb_miss,
  input  btb_inv_t                 inv,
  output btb_refill_wr_t           refill_wr
);

  // Pending entry fields
  logic [BTB_INDEX_W-1:0]   buf_index;
  logic [BTB_TAG_W-1:0]     buf_tag;
  logic [BTB_TARGET_W-1:0]  buf_target;
  logic [BTB_WAYPRED_W-1:0] buf_way_pred;
  logic                     buf_valid;
  // Two-stage tracking of the way prediction arrival
  logic                     capt_first;
  logic                     capt_second;

  //======================================================================
  //  Entry capture from address generation
  //======================================================================
  // Invalidation wipes a half-built entry as well
  always_ff @(posedge refill_buf_updt_clk)
  begin
    if (inv.active)
    begin
      buf_index  <= '0;
      buf_tag    <= '0;
      buf_target <= '0;
    end
    else if (update.vld)
    begin
      buf_index  <= update.index;
      buf_tag    <= update.tag;
      buf_target <= update.target;
    end
  end

  //======================================================================
  //  Way prediction pipeline and valid
  //======================================================================
  // Icache way prediction shows up two cycles behind the target
  // Stall in the middle cycle loses it, entry stays invalid
  always_ff @(posedge refill_buf_updt_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      capt_first   <= 1'b0;
      capt_second  <= 1'b0;
      buf_way_pred <= BTB_WAYPRED_RST;
      buf_valid    <= 1'b0;
    end
    else if (inv.active)
    begin
      capt_first   <= 1'b0;
      capt_second  <= 1'b0;
      buf_way_pred <= BTB_WAYPRED_RST;
      buf_valid    <= 1'b0;
    end
    else
    begin
      capt_first  <= update.vld;
      // New update restarts the sequence
      capt_second <= capt_first && !pcgen_stall && !update.vld;
      if (capt_second && !update.vld)
        buf_way_pred <= way_pred;
      if (update.vld)
        buf_valid <= 1'b0;
      else if (capt_second)
        buf_valid <= 1'b1;
      // Entry goes out with this miss
      else if (ibdp_btb_miss)
        buf_valid <= 1'b0;
    end
  end

  //======================================================================
  //  Write request
  //======================================================================
  // Same-cycle write on a miss, way picked later from tag bits
  always_comb
  begin
    refill_wr.vld            = buf_valid && ibdp_btb_miss && !inv.active;
    refill_wr.index          = buf_index;
    refill_wr.entry.vld      = 1'b1;
    refill_wr.entry.tag      = buf_tag;
    refill_wr.entry.way_pred = buf_way_pred;
    refill_wr.entry.target   = buf_target;
  end

endmodule

//--- logic/btb_top.sv
// Single clock domain; caller must run one invalidation after reset before trusting lookup results
`timescale 1ns/1ps

module btb_top
  import btb_geom_pkg::*, btb_types_pkg::*;
(
  input  logic                     refill_buf_updt_clk,
  input  logic                     cpurst_b,
  input  btb_lookup_req_t          lookup,
  input  btb_update_t              update,
  input  logic [BTB_WAYPRED_W-1:0] way_pred,
  input  logic                     pcgen_stall,
  input  logic                     ibdp_btb_miss,
  input  logic                     ifctrl_btb_inv,
  input  logic                     cp0_ifu_btb_en,
  output btb_set_t                 result,
  output logic                     result_vld,
  output logic                     inv_on,
  output logic                     inv_done
);

  // Refill buffer to array
  btb_refill_wr_t refill_wr;
  // Walk state to buffer and array
  btb_inv_t       inv;

  //======================================================================
  //  Input side
  //======================================================================
  btb_refill_buf u_btb_refill_buf (
    .refill_buf_updt_clk (refill_buf_updt_clk),
    .cpurst_b            (cpurst_b),
    .update              (update),
    .way_pred            (way_pred),
    .pcgen_stall         (pcgen_stall),
    .ibdp_btb_miss       (ibdp_btb_miss),
    .inv                 (inv),
    .refill_wr           (refill_wr)
  );

  btb_inv_ctrl u_btb_inv_ctrl (
    .refill_buf_updt_clk (refill_buf_updt_clk),
    .cpurst_b            (cpurst_b),
    .ifctrl_btb_inv      (ifctrl_btb_inv),
    .inv                 (inv),
    .inv_on              (inv_on),
    .inv_done            (inv_done)
  );

  //======================================================================
  //  Storage and read result
  //======================================================================
  btb_array u_btb_array (
    .refill_buf_updt_clk (refill_buf_updt_clk),
    .cpurst_b            (cpurst_b),
    .cp0_ifu_btb_en      (cp0_ifu_btb_en),
    .lookup              (lookup),
    .refill_wr           (refill_wr),
    .inv                 (inv),
    .result              (result),
    .result_vld          (result_vld)
  );

endmodule

//--- logic/btb_types_pkg.sv
// Bundles exchanged between the BTB blocks; field widths follow btb_geom_pkg and must not be resized here
package btb_types_pkg;

  import btb_geom_pkg::*;

  //======================================================================
  //  Stored content
  //======================================================================
  // One way of one set, 33 bits
  typedef struct packed {
    logic                     vld;
    logic [BTB_TAG_W-1:0]     tag;
    logic [BTB_WAYPRED_W-1:0] way_pred;
    logic [BTB_TARGET_W-1:0]  target;
  } btb_entry_t;

  // All four ways of a set, way 3 in the top bits
  typedef struct packed {
    btb_entry_t [BTB_WAYS-1:0] way;
  } btb_set_t;

  //======================================================================
  //  Requests
  //======================================================================
  // Fetch lookup from pc generation
  typedef struct packed {
    logic                   vld;
    logic [BTB_INDEX_W-1:0] index;
  } btb_lookup_req_t;

  // New branch info from address generation
  typedef struct packed {
    logic                    vld;
    logic [BTB_INDEX_W-1:0]  index;
    logic [BTB_TAG_W-1:0]    tag;
    logic [BTB_TARGET_W-1:0] target;
  } btb_update_t;

  // One-way write out of the refill buffer
  typedef struct packed {
    logic                   vld;
    logic [BTB_INDEX_W-1:0] index;
    btb_entry_t             entry;
  } btb_refill_wr_t;

  // Invalidation walk state
  typedef struct packed {
    logic                   active;
    logic [BTB_INDEX_W-1:0] index;
  } btb_inv_t;

endpackage

//--- verification/tb_btb_top.sv
// Inputs change and outputs are sampled on the falling edge and array contents count only after the first invalidation walk
`timescale 1ns/1ps

module tb_btb_top
  import btb_geom_pkg::*, btb_types_pkg::*;
();

  localparam int unsigned INV_LIMIT  = 600;
  localparam int unsigned RES_LIMIT  = 8;
  localparam int unsigned FILL_COUNT = 24;

  logic                     refill_buf_updt_clk;
  logic                     cpurst_b;
  btb_lookup_req_t          lookup;
  btb_update_t              update;
  logic [BTB_WAYPRED_W-1:0] way_pred;
  logic                     pcgen_stall;
  logic                     ibdp_btb_miss;
  logic                     ifctrl_btb_inv;
  logic                     cp0_ifu_btb_en;
  btb_set_t                 result;
  logic                     result_vld;
  logic                     inv_on;
  logic                     inv_done;

  //======================================================================
  //  Reference state
  //======================================================================
  // Model array and pending refill entry
  btb_set_t               model_mem [BTB_SETS];
  btb_entry_t             model_buf;
  logic [BTB_INDEX_W-1:0] model_buf_index;
  logic                   model_buf_vld;
  // Expected sets of accepted lookups in order
  btb_set_t               exp_q [$];
  logic [31:0]            rng_state;
  int                     mismatch_cnt;
  int                     fail_cnt;

  btb_top u_btb_top (
    .refill_buf_updt_clk (refill_buf_updt_clk),
    .cpurst_b            (cpurst_b),
    .lookup              (lookup),
    .update              (update),
    .way_pred            (way_pred),
    .pcgen_stall         (pcgen_stall),
    .ibdp_btb_miss       (ibdp_btb_miss),
    .ifctrl_btb_inv      (ifctrl_btb_inv),
    .cp0_ifu_btb_en      (cp0_ifu_btb_en),
    .result              (result),
    .result_vld          (result_vld),
    .inv_on              (inv_on),
    .inv_done            (inv_done)
  );

  initial
  begin
    refill_buf_updt_clk = 1'b0;
    forever #10 refill_buf_updt_clk = ~refill_buf_updt_clk;
  end

  // xorshift32 step
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Expected lookup result with valid bits gated by the enable
  function automatic btb_set_t expected_set(input logic [BTB_INDEX_W-1:0] idx);
    btb_set_t s;
    int       w;
    s = model_mem[idx];
    for (w = 0; w < BTB_WAYS; w++)
      s.way[w].vld = s.way[w].vld && cp0_ifu_btb_en;
    return s;
  endfunction

  // Miss commits a valid buffer into way tag[2:1]
  // Buffer empties either way
  function automatic void model_miss();
    int w;
    if (model_buf_vld && cp0_ifu_btb_en)
    begin
      w = model_buf.tag[2:1];
      model_mem[model_buf_index].way[w] = model_buf;
    end
    model_buf_vld = 1'b0;
  endfunction

  task automatic report_mismatch(input string msg);
    mismatch_cnt++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  task automatic note_failure(input string msg);
    fail_cnt++;
    $display("%s at %0t", msg, $time);
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic fail_timeout(input string msg);
    note_failure(msg);
    finish_run();
  endtask

  //======================================================================
  //  Stimulus tasks entered right after a falling edge
  //======================================================================
  // Drain queued results
  // One idle cycle more catches stray pulses
  task automatic wait_results();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < RES_LIMIT)
    begin
      @(negedge refill_buf_updt_clk);
      cycles++;
    end
    if (exp_q.size() != 0)
      fail_timeout("lookup result never came back");
    @(negedge refill_buf_updt_clk);
  endtask

  // Optional miss in the same cycle as the lookup
  task automatic issue_lookup(input logic [BTB_INDEX_W-1:0] idx, input logic with_miss);
    lookup.vld    = 1'b1;
    lookup.index  = idx;
    ibdp_btb_miss = with_miss;
    // Read dropped by a live refill write or a disabled BTB
    if (cp0_ifu_btb_en && !(with_miss && model_buf_vld))
      exp_q.push_back(expected_set(idx));
    if (with_miss)
      model_miss();
    @(negedge refill_buf_updt_clk);
    lookup.vld    = 1'b0;
    ibdp_btb_miss = 1'b0;
    wait_results();
  endtask

  task automatic pulse_miss();
    ibdp_btb_miss = 1'b1;
    model_miss();
    @(negedge refill_buf_updt_clk);
    ibdp_btb_miss = 1'b0;
  endtask

  // Update with optional stall in the next cycle
  // Way prediction held throughout
  task automatic load_update(input logic [BTB_INDEX_W-1:0] idx, input logic stall);
    update.vld    = 1'b1;
    update.index  = idx;
    update.tag    = BTB_TAG_W'(next_rand());
    update.target = BTB_TARGET_W'(next_rand());
    way_pred      = BTB_WAYPRED_W'(next_rand());
    @(negedge refill_buf_updt_clk);
    update.vld  = 1'b0;
    pcgen_stall = stall;
    @(negedge refill_buf_updt_clk);
    pcgen_stall = 1'b0;
    @(negedge refill_buf_updt_clk);
    // Way prediction captured two edges after the update
    model_buf_index    = idx;
    model_buf.vld      = 1'b1;
    model_buf.tag      = update.tag;
    model_buf.way_pred = way_pred;
    model_buf.target   = update.target;
    model_buf_vld      = !stall;
  endtask

  // One full walk with inv_on high for exactly one cycle per set
  task automatic invalidate_all();
    int cycles;
    int s;
    ifctrl_btb_inv = 1'b1;
    @(negedge refill_buf_updt_clk);
    ifctrl_btb_inv = 1'b0;
    cycles = 0;
    while (inv_on && cycles < INV_LIMIT)
    begin
      assert (!inv_done)
      else
        report_mismatch("inv_done high during the walk");
      cycles++;
      @(negedge refill_buf_updt_clk);
    end
    if (inv_on)
      fail_timeout("invalidation walk did not finish");
    assert (cycles == BTB_SETS && inv_done)
    else
      report_mismatch($sformatf("inv_on high for %0d cycles, expected %0d", cycles, BTB_SETS));
    for (s = 0; s < BTB_SETS; s++)
      model_mem[s] = '0;
    model_buf_vld = 1'b0;
  endtask

  // Held result shows no valid way while the BTB is off
  task automatic check_result_hidden();
    int w;
    for (w = 0; w < BTB_WAYS; w++)
      assert (!result.way[w].vld)
      else
        report_mismatch($sformatf("way %0d valid with the BTB disabled", w));
  endtask

  //======================================================================
  //  Result checker
  //======================================================================
  always @(negedge refill_buf_updt_clk)
  begin : result_check
    btb_set_t want;
    int       w;
    if (cpurst_b && result_vld)
    begin
      assert (exp_q.size() != 0)
      else
        note_failure("result_vld pulsed with no lookup accepted");
      if (exp_q.size() != 0)
      begin
        want = exp_q.pop_front();
        for (w = 0; w < BTB_WAYS; w++)
          assert (result.way[w] == want.way[w])
          else
            report_mismatch($sformatf("way %0d got %h expected %h",
                                      w, result.way[w], want.way[w]));
      end
    end
  end

  //======================================================================
  //  Test sequence
  //======================================================================
  initial
  begin : main_seq
    logic [BTB_INDEX_W-1:0] idx;
    logic [BTB_INDEX_W-1:0] filled [$];
    rng_state      = 32'h516;
    mismatch_cnt   = 0;
    fail_cnt       = 0;
    model_buf_vld  = 1'b0;
    cpurst_b       = 1'b0;
    lookup         = '0;
    update         = '0;
    way_pred       = '0;
    pcgen_stall    = 1'b0;
    ibdp_btb_miss  = 1'b0;
    ifctrl_btb_inv = 1'b0;
    cp0_ifu_btb_en = 1'b1;
    repeat (16) @(negedge refill_buf_updt_clk);
    cpurst_b = 1'b1;
    @(negedge refill_buf_updt_clk);
    assert (!result_vld && !inv_on && inv_done)
    else
      report_mismatch($sformatf("after reset result_vld %b inv_on %b inv_done %b",
                                result_vld, inv_on, inv_done));
    // Random sets read back empty after the walk
    invalidate_all();
    repeat (8) issue_lookup(BTB_INDEX_W'(next_rand()), 1'b0);
    // Random fills
    repeat (FILL_COUNT)
    begin
      idx = BTB_INDEX_W'(next_rand());
      filled.push_back(idx);
      load_update(idx, 1'b0);
      pulse_miss();
      issue_lookup(idx, 1'b0);
    end
    // Stalled capture leaves nothing for the miss to write
    load_update(filled[0], 1'b1);
    issue_lookup(filled[0], 1'b1);
    // Second miss after a write finds the buffer empty
    load_update(filled[0], 1'b0);
    pulse_miss();
    issue_lookup(filled[0], 1'b1);
    // BTB off
    cp0_ifu_btb_en = 1'b0;
    issue_lookup(filled[1], 1'b0);
    check_result_hidden();
    load_update(filled[1], 1'b0);
    pulse_miss();
    cp0_ifu_btb_en = 1'b1;
    issue_lookup(filled[1], 1'b0);
    // Read collides with the refill write
    idx = BTB_INDEX_W'(next_rand());
    filled.push_back(idx);
    load_update(idx, 1'b0);
    issue_lookup(idx, 1'b1);
    issue_lookup(idx, 1'b0);
    // Second walk wipes everything written
    invalidate_all();
    foreach (filled[i])
      issue_lookup(filled[i], 1'b0);
    finish_run();
  end

endmodule

//--- verilog.f
logic/btb_geom_pkg.sv
logic/btb_types_pkg.sv
logic/btb_refill_buf.sv
logic/btb_inv_ctrl.sv
logic/btb_array.sv
logic/btb_top.sv
verification/tb_btb_top.sv
